/* design/chipBridgePkg.sv */
/*
 * chipBridgePkg: shared types for the 68040 to Amiga chip bus bridge,
 * covering SIZ codes, the CPU request, chip bus outputs, lane enables and config
 */
package chipBridgePkg;

    // SIZ encoding as the 68040 drives it, equal bits mean a longword
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11 // a line is split by the CPU, here it counts as a longword
    } sizeCode;

    // one CPU transfer request, valid in the cycle of ts
    typedef struct packed {
        logic [23:0] addr;
        sizeCode     siz;
        logic        rw;    // high for a read
        logic [31:0] wdata;
    } cpuReq_t;

    // everything the bridge puts on the 16-bit chip bus
    typedef struct packed {
        logic [22:0] addr;   // word address, bits 23..1 of the byte address
        logic        uds;    // upper data strobe, active high here
        logic        lds;    // lower data strobe, active high here
        logic        rw;
        logic        strobe; // high in every cycle of an active word phase
        logic [15:0] wdata;
    } chipBus_t;

    // active low byte lane enables, upper lane first
    typedef struct packed {
        logic uub;
        logic umb;
        logic lmb;
        logic llb;
    } laneEnables_t;

    // chipset DMA strobes, all active low
    typedef struct packed {
        logic casUn;
        logic casLn;
        logic dbenN; // high picks the upper lane pair
    } dmaStrobes_t;

    // bridge configuration word
    typedef struct packed {
        logic [1:0] waitStates; // extra cycles per word phase
        logic       dmaEnable;
    } bridgeCfg_t;

endpackage

/* design/byteEnable.sv */
/*
 * byteEnable: decodes SIZ and A[1:0] into byte lane enables and chip bus
 * data strobes, and forwards DMA CAS strobes onto the chip RAM lanes
 */
`timescale 1ns/10ps

module byteEnable import chipBridgePkg::*; (
    input  logic         cpuCycle,
    input  logic         dmaGrant,
    input  logic [1:0]   addrLow,
    input  sizeCode      siz,
    input  dmaStrobes_t  dma,
    output laneEnables_t memEnables,
    output laneEnables_t ramEnables,
    output logic         uds,
    output logic         lds
);

    logic isLong; // longword or line, both move four bytes
    logic isWord;
    logic uubHit; // lane hits, active high, before any gating
    logic umbHit;
    logic lmbHit;
    logic llbHit;
    logic dmaUpper; // DMA cycle on the upper pair
    logic dmaLower; // DMA cycle on the lower pair

    assign isLong = (siz == sizeLong) || (siz == sizeLine);
    assign isWord = (siz == sizeWord);

    // a word covers both lanes of the half that A1 picks, a byte only its own lane
    assign uubHit = isLong || (!addrLow[1] && (isWord || !addrLow[0]));
    assign umbHit = isLong || (!addrLow[1] && (isWord ||  addrLow[0]));
    assign lmbHit = isLong || ( addrLow[1] && (isWord || !addrLow[0]));
    assign llbHit = isLong || ( addrLow[1] && (isWord ||  addrLow[0]));

    // memory enables only ever belong to the CPU
    assign memEnables.uub = !(uubHit && cpuCycle);
    assign memEnables.umb = !(umbHit && cpuCycle);
    assign memEnables.lmb = !(lmbHit && cpuCycle);
    assign memEnables.llb = !(llbHit && cpuCycle);

    // dbenN picks which pair the chipset is talking to
    assign dmaUpper = dmaGrant &&  dma.dbenN;
    assign dmaLower = dmaGrant && !dma.dbenN;

    // chip RAM lanes take the CPU decode or the CAS strobes, casUn to the upper lane of the pair
    assign ramEnables.uub = !((uubHit && cpuCycle) || (!dma.casUn && dmaUpper));
    assign ramEnables.umb = !((umbHit && cpuCycle) || (!dma.casLn && dmaUpper));
    assign ramEnables.lmb = !((lmbHit && cpuCycle) || (!dma.casUn && dmaLower));
    assign ramEnables.llb = !((llbHit && cpuCycle) || (!dma.casLn && dmaLower));

    // 68000 style strobes for the 16-bit side, quiet outside a CPU cycle
    assign uds = cpuCycle && !addrLow[0];
    assign lds = cpuCycle && (addrLow[0] || isWord || isLong); // odd byte, word or long

endmodule

/* design/cycleSequencer.sv */
/*
 * cycleSequencer: arbitrates CPU requests against chipset DMA and runs the
 * 16-bit word phases with wait states, ending each CPU transfer with ta
 */
`timescale 1ns/10ps

module cycleSequencer import chipBridgePkg::*; (
    input  logic        clk40,
    input  logic        rstN,
    input  logic        ts,
    input  cpuReq_t     req,
    input  logic        dmaReq,
    input  bridgeCfg_t  cfg,
    output logic        cpuCycle,
    output logic        dmaGrant,
    output logic        ta,
    output logic        upperPhase,
    output logic        lastCycle,
    output cpuReq_t     latchedReq,
    output logic [22:0] chipAddr,
    output logic        strobe
);

    // sequencer states
    typedef enum logic [1:0] {
        stIdle = 2'd0,
        stCpu  = 2'd1, // word phases running
        stDma  = 2'd2, // chipset owns the chip RAM
        stAck  = 2'd3  // single ta cycle
    } seqState_t;

    seqState_t  state;
    logic       tsPending; // ts seen while DMA held the bus
    logic [1:0] waitCnt;   // cycle count inside the current word phase
    logic [1:0] wsLatched; // wait states frozen for this transfer
    logic       phase;     // second word of a longword when set
    logic       isLong;
    logic       phaseDone;

    assign isLong    = (latchedReq.siz == sizeLong) || (latchedReq.siz == sizeLine);
    assign phaseDone = (waitCnt == wsLatched);

    always_ff @(posedge clk40) begin
        if (!rstN) begin
            state     <= stIdle;
            tsPending <= 1'b0;
            waitCnt   <= 2'd0;
            wsLatched <= 2'd0;
            phase     <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    // the CPU wins a tie with a fresh DMA request
                    if (ts || tsPending) begin
                        state     <= stCpu;
                        tsPending <= 1'b0;
                        waitCnt   <= 2'd0;
                        phase     <= 1'b0;
                        wsLatched <= cfg.waitStates; // later config writes leave this transfer alone
                    end else if (dmaReq && cfg.dmaEnable) begin
                        state <= stDma;
                    end
                end
                stCpu: begin
                    if (phaseDone) begin
                        waitCnt <= 2'd0;
                        if (isLong && !phase) begin
                            phase <= 1'b1; // straight into the lower word, no gap
                        end else begin
                            state <= stAck;
                        end
                    end else begin
                        waitCnt <= waitCnt + 2'd1;
                    end
                end
                stDma: begin
                    if (ts) begin
                        tsPending <= 1'b1; // park it until the chipset lets go
                    end
                    if (!dmaReq) begin
                        state <= stIdle;
                    end
                end
                stAck: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // request payload, only loaded on ts so a pending request survives DMA
    always_ff @(posedge clk40) begin
        if (ts) begin
            latchedReq <= req;
        end
    end

    assign cpuCycle = (state == stCpu) || (state == stAck); // ta cycle included
    assign dmaGrant = (state == stDma);
    assign ta       = (state == stAck);
    assign strobe   = (state == stCpu);
    assign lastCycle = strobe && phaseDone; // read data gets sampled here

    // longwords go upper then lower, shorter sizes use the half that A1 names
    assign upperPhase = isLong ? !phase : !latchedReq.addr[1];
    assign chipAddr   = {latchedReq.addr[23:2], isLong ? phase : latchedReq.addr[1]};

endmodule

/* design/dataSteer.sv */
/*
 * dataSteer: puts the right 16-bit half of the CPU write data on the chip
 * bus and builds the 32-bit read word from one or two word phases
 */
`timescale 1ns/10ps

module dataSteer (
    input  logic        clk40,
    input  logic        rstN,
    input  logic        upperPhase,
    input  logic        lastCycle,
    input  logic        strobe,
    input  logic [31:0] wdata,
    input  logic [15:0] chipRdata,
    output logic [15:0] chipWdata,
    output logic [31:0] cpuRdata
);

    logic [15:0] upperHalf; // D31..D16 as seen by the CPU
    logic [15:0] lowerHalf; // D15..D0
    logic        capture;   // last strobe cycle of a word phase

    // the lane for the current phase goes out as is, no delay
    assign chipWdata = upperPhase ? wdata[31:16] : wdata[15:0];

    assign capture = strobe && lastCycle;

    // the chip bus data is only trusted at the end of the phase
    always_ff @(posedge clk40) begin
        if (!rstN) begin
            upperHalf <= 16'h0000;
            lowerHalf <= 16'h0000;
        end else if (capture) begin
            if (upperPhase) begin
                upperHalf <= chipRdata;
            end else begin
                lowerHalf <= chipRdata;
            end
        end
    end

    // the half that was not read keeps its old value, the CPU ignores those lanes
    assign cpuRdata = {upperHalf, lowerHalf};

endmodule

/* design/bridgeConfig.sv */
/*
 * bridgeConfig: register block holding wait states and DMA enable for the
 * sequencer, written by a single cycle strobe and always readable
 */
`timescale 1ns/10ps

module bridgeConfig import chipBridgePkg::*; #(
    parameter int RESET_WAIT_STATES = 1 // 0 to 3
) (
    input  logic       clk40,
    input  logic       rstN,
    input  logic       cfgWrite,
    input  bridgeCfg_t cfgWdata,
    output bridgeCfg_t cfg,
    output bridgeCfg_t cfgRdata
);

    bridgeCfg_t cfgReg;

    always_ff @(posedge clk40) begin
        if (!rstN) begin
            cfgReg.waitStates <= 2'(RESET_WAIT_STATES);
            cfgReg.dmaEnable  <= 1'b1; // chipset DMA is allowed out of reset
        end else if (cfgWrite) begin
            cfgReg <= cfgWdata; // visible from the next cycle on
        end
    end

    // the sequencer and the readback port see the same register
    assign cfg      = cfgReg;
    assign cfgRdata = cfgReg;

endmodule

/* design/chipBridge.sv */
/*
 * chipBridge: 32-bit 68040 bus to 16-bit Amiga chip bus bridge with
 * DMA arbitration, byte lane decode and a small config block
 */
`timescale 1ns/10ps

module chipBridge import chipBridgePkg::*; #(
    parameter int RESET_WAIT_STATES = 1
) (
    input  logic         clk40,
    input  logic         rstN,
    input  logic         ts,
    input  cpuReq_t      req,
    input  logic         dmaReq,
    input  dmaStrobes_t  dma,
    input  logic         cfgWrite,
    input  bridgeCfg_t   cfgWdata,
    input  logic [15:0]  chipRdata,
    output logic         ta,
    output logic [31:0]  cpuRdata,
    output logic         cpuCycle,
    output logic         dmaGrant,
    output chipBus_t     chipBus,
    output laneEnables_t memEnables,
    output laneEnables_t ramEnables,
    output bridgeCfg_t   cfgRdata
);

    bridgeCfg_t  cfg;
    cpuReq_t     latchedReq;
    logic        upperPhase;
    logic        lastCycle;
    logic        strobe;
    logic [22:0] chipAddr;
    logic        uds;
    logic        lds;
    logic [15:0] chipWdata;

    bridgeConfig #(
        .RESET_WAIT_STATES(RESET_WAIT_STATES)
    ) config_i (
        .clk40   (clk40),
        .rstN    (rstN),
        .cfgWrite(cfgWrite),
        .cfgWdata(cfgWdata),
        .cfg     (cfg),
        .cfgRdata(cfgRdata)
    );

    cycleSequencer sequencer_i (
        .clk40     (clk40),
        .rstN      (rstN),
        .ts        (ts),
        .req       (req),
        .dmaReq    (dmaReq),
        .cfg       (cfg),
        .cpuCycle  (cpuCycle),
        .dmaGrant  (dmaGrant),
        .ta        (ta),
        .upperPhase(upperPhase),
        .lastCycle (lastCycle),
        .latchedReq(latchedReq),
        .chipAddr  (chipAddr),
        .strobe    (strobe)
    );

    // decode runs off the latched request so it holds for the whole CPU cycle
    byteEnable byteEnable_i (
        .cpuCycle  (cpuCycle),
        .dmaGrant  (dmaGrant),
        .addrLow   (latchedReq.addr[1:0]),
        .siz       (latchedReq.siz),
        .dma       (dma),
        .memEnables(memEnables),
        .ramEnables(ramEnables),
        .uds       (uds),
        .lds       (lds)
    );

    dataSteer dataSteer_i (
        .clk40     (clk40),
        .rstN      (rstN),
        .upperPhase(upperPhase),
        .lastCycle (lastCycle),
        .strobe    (strobe),
        .wdata     (latchedReq.wdata),
        .chipRdata (chipRdata),
        .chipWdata (chipWdata),
        .cpuRdata  (cpuRdata)
    );

    // chip bus outputs gathered into one struct
    assign chipBus.addr   = chipAddr;
    assign chipBus.uds    = uds;
    assign chipBus.lds    = lds;
    assign chipBus.rw     = latchedReq.rw;
    assign chipBus.strobe = strobe;
    assign chipBus.wdata  = chipWdata;

endmodule

/* verification/chipBusModel.sv */
/*
 * chipBusModel: testbench responder for the 16-bit chip bus, a 16-word
 * memory written through uds/lds and read back combinationally
 */
`timescale 1ns/10ps

module chipBusModel import chipBridgePkg::*; (
    input  logic        clk40,
    input  chipBus_t    chipBus,
    output logic [15:0] chipRdata
);

    logic [15:0] mem [0:15]; // indexed by the low four word address bits

    // start from a pattern that differs in every word
    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] = {4'(i), ~4'(i), 4'(i) ^ 4'hA, 4'hF - 4'(i)};
        end
    end

    // a write repeats on every strobe cycle of the phase, the last one is what stays
    always @(posedge clk40) begin
        if (chipBus.strobe && !chipBus.rw) begin
            if (chipBus.uds) begin
                mem[chipBus.addr[3:0]][15:8] <= chipBus.wdata[15:8]; // even byte
            end
            if (chipBus.lds) begin
                mem[chipBus.addr[3:0]][7:0] <= chipBus.wdata[7:0];   // odd byte
            end
        end
    end

    assign chipRdata = mem[chipBus.addr[3:0]]; // no read latency on the chip bus

endmodule

/* verification/chipBridgeTb.sv */
/*
 * chipBridgeTb: drives random CPU transfers, DMA and config writes into the
 * bridge and checks it against a cycle model with concurrent assertions
 */
`timescale 1ns/10ps

module chipBridgeTb
    import chipBridgePkg::*;
();

    localparam int RESET_WS        = 1;
    localparam int PREFILL_XFERS   = 8;  // longwords that cover the whole model memory
    localparam int RANDOM_XFERS    = 40;
    localparam int WS_XFERS        = 4;  // per wait state setting
    localparam int TOTAL_XFERS     = PREFILL_XFERS + RANDOM_XFERS + 2 * WS_XFERS + 3;
    localparam int WATCHDOG_CYCLES = TOTAL_XFERS * 9 + 200;
    localparam int WAIT_LIMIT      = 40; // cycles before a handshake counts as lost

    logic         clk40;
    logic         rstN;
    logic         ts;
    cpuReq_t      req;
    logic         dmaReq;
    dmaStrobes_t  dma;
    logic         cfgWrite;
    bridgeCfg_t   cfgWdata;
    logic [15:0]  chipRdata;
    logic         ta;
    logic [31:0]  cpuRdata;
    logic         cpuCycle;
    logic         dmaGrant;
    chipBus_t     chipBus;
    laneEnables_t memEnables;
    laneEnables_t ramEnables;
    bridgeCfg_t   cfgRdata;

    int          errorCount = 0;
    int          transferCount = 0;
    int unsigned lcgState = 29231;
    string       testName;

    // reference model state, all of it moves on the rising edge
    cpuReq_t     curReq;      // request of the transfer under way or waiting
    logic [4:0]  sinceAccept; // 0 when no CPU cycle, then counts up to the ta cycle
    logic [1:0]  expWaits;    // wait states frozen at acceptance
    logic        tsWaiting;   // ts arrived under DMA
    logic        expGrant;
    bridgeCfg_t  tbCfg;
    logic [7:0]  refMem [0:31];

    logic         isLongReq;
    logic [3:0]   hit; // touched lanes, active high, uub first
    logic [4:0]   expLatency;
    logic [4:0]   phaseIdx;
    logic         expTa;
    logic         expCpu;
    logic         expStrobe;
    logic [22:0]  expChipAddr;
    laneEnables_t expMem;
    laneEnables_t expRam;
    logic         expUds;
    logic         expLds;
    logic [31:0]  expRdata;
    logic [31:0]  readMask;

    chipBridge #(
        .RESET_WAIT_STATES(RESET_WS)
    ) dut_i (
        .clk40(clk40), .rstN(rstN), .ts(ts), .req(req), .dmaReq(dmaReq), .dma(dma),
        .cfgWrite(cfgWrite), .cfgWdata(cfgWdata), .chipRdata(chipRdata), .ta(ta),
        .cpuRdata(cpuRdata), .cpuCycle(cpuCycle), .dmaGrant(dmaGrant), .chipBus(chipBus),
        .memEnables(memEnables), .ramEnables(ramEnables), .cfgRdata(cfgRdata)
    );

    chipBusModel busModel_i (
        .clk40    (clk40),
        .chipBus  (chipBus),
        .chipRdata(chipRdata)
    );

    initial begin
        clk40 = 1'b0;
        forever #2 clk40 = ~clk40; // 4 ns period
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {lcgState[15:0], lcgState[31:16]}; // high state bits land in the low bits
    endfunction

    // lanes a transfer touches, big endian, A1 picks the half and A0 the byte
    function automatic logic [3:0] touchedLanes(input sizeCode siz, input logic [1:0] low);
        case (siz)
            sizeByte: return 4'b1000 >> low;
            sizeWord: return low[1] ? 4'b0011 : 4'b1100;
            default:  return 4'b1111; // long and line
        endcase
    endfunction

    function automatic cpuReq_t randomReq(input logic rw);
        cpuReq_t     r;
        logic [31:0] pick;
        pick    = nextRandom();
        r.addr  = pick[23:0];
        r.rw    = rw;
        r.wdata = nextRandom();
        case (pick[25:24])
            2'd0:    r.siz = sizeByte;
            2'd1:    r.siz = sizeWord;
            2'd2:    r.siz = sizeLong;
            default: r.siz = sizeLine;
        endcase
        if (r.siz == sizeWord) begin
            r.addr[0] = 1'b0;
        end else if (r.siz != sizeByte) begin
            r.addr[1:0] = 2'b00;
        end
        return r;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("Error %s %s: expected %h actual %h", testName, what, expected, actual);
    endtask

    // cycle model of arbitration, phases and config, built from the bus rules
    always @(posedge clk40) begin
        if (!rstN) begin
            sinceAccept <= 5'd0;
            expWaits    <= 2'd0;
            tsWaiting   <= 1'b0;
            expGrant    <= 1'b0;
            tbCfg       <= {2'(RESET_WS), 1'b1};
        end else begin
            if (cfgWrite) begin
                tbCfg <= cfgWdata;
            end
            if (sinceAccept == 5'd0 && !expGrant) begin
                if (ts || tsWaiting) begin // CPU first, DMA waits
                    sinceAccept <= 5'd1;
                    tsWaiting   <= 1'b0;
                    expWaits    <= tbCfg.waitStates;
                end else if (dmaReq && tbCfg.dmaEnable) begin
                    expGrant <= 1'b1;
                end
            end else if (expGrant) begin
                if (ts) begin
                    tsWaiting <= 1'b1;
                end
                if (!dmaReq) begin
                    expGrant <= 1'b0;
                end
            end else if (sinceAccept == expLatency) begin
                sinceAccept <= 5'd0;
                for (int lane = 0; lane < 4; lane++) begin
                    if (!curReq.rw && hit[3 - lane]) begin
                        refMem[{curReq.addr[4:2], 2'(lane)}] <= curReq.wdata[31 - 8 * lane -: 8];
                    end
                end
            end else begin
                sinceAccept <= sinceAccept + 5'd1;
            end
        end
    end

    assign isLongReq   = (curReq.siz == sizeLong) || (curReq.siz == sizeLine);
    assign hit         = touchedLanes(curReq.siz, curReq.addr[1:0]);
    assign expLatency  = (isLongReq ? 5'd2 : 5'd1) * ({3'b0, expWaits} + 5'd1) + 5'd1;
    assign phaseIdx    = (sinceAccept - 5'd1) / ({3'b0, expWaits} + 5'd1); // only read under strobe
    assign expTa       = (sinceAccept == expLatency);
    assign expCpu      = (sinceAccept != 5'd0);
    assign expStrobe   = expCpu && !expTa;
    assign expChipAddr = {curReq.addr[23:2], isLongReq ? phaseIdx[0] : curReq.addr[1]};
    assign expUds      = expCpu && !curReq.addr[0];
    assign expLds      = expCpu && (curReq.addr[0] || curReq.siz != sizeByte);
    assign expMem      = expCpu ? ~hit : 4'hF;
    // casUn takes the upper lane of the pair that dbenN selects
    assign expRam = expCpu   ? ~hit :
                    expGrant ? (dma.dbenN ? {dma.casUn, dma.casLn, 2'b11}
                                          : {2'b11, dma.casUn, dma.casLn}) : 4'hF;
    assign readMask = {{8{hit[3]}}, {8{hit[2]}}, {8{hit[1]}}, {8{hit[0]}}};
    assign expRdata = {refMem[{curReq.addr[4:2], 2'd0}], refMem[{curReq.addr[4:2], 2'd1}],
                       refMem[{curReq.addr[4:2], 2'd2}], refMem[{curReq.addr[4:2], 2'd3}]};

    assert property (@(posedge clk40) disable iff (!rstN) ta == expTa)
        else reportMismatch("ta", $sampled(expTa), $sampled(ta));
    assert property (@(posedge clk40) disable iff (!rstN) cpuCycle == expCpu)
        else reportMismatch("cpuCycle", $sampled(expCpu), $sampled(cpuCycle));
    assert property (@(posedge clk40) disable iff (!rstN) dmaGrant == expGrant)
        else reportMismatch("dmaGrant", $sampled(expGrant), $sampled(dmaGrant));
    assert property (@(posedge clk40) disable iff (!rstN) chipBus.strobe == expStrobe)
        else reportMismatch("strobe", $sampled(expStrobe), $sampled(chipBus.strobe));
    assert property (@(posedge clk40) disable iff (!rstN)
                     chipBus.strobe |-> chipBus.addr == expChipAddr)
        else reportMismatch("chip addr", $sampled(expChipAddr), $sampled(chipBus.addr));
    assert property (@(posedge clk40) disable iff (!rstN) memEnables == expMem)
        else reportMismatch("memEnables", $sampled(expMem), $sampled(memEnables));
    assert property (@(posedge clk40) disable iff (!rstN) ramEnables == expRam)
        else reportMismatch("ramEnables", $sampled(expRam), $sampled(ramEnables));
    assert property (@(posedge clk40) disable iff (!rstN)
                     {chipBus.uds, chipBus.lds} == {expUds, expLds})
        else reportMismatch("uds lds", $sampled({expUds, expLds}),
                            $sampled({chipBus.uds, chipBus.lds}));
    assert property (@(posedge clk40) disable iff (!rstN)
                     (ta && curReq.rw) |-> (cpuRdata & readMask) == (expRdata & readMask))
        else reportMismatch("read data", $sampled(expRdata & readMask),
                            $sampled(cpuRdata & readMask));
    assert property (@(posedge clk40) disable iff (!rstN) cfgRdata == tbCfg)
        else reportMismatch("cfgRdata", $sampled(tbCfg), $sampled(cfgRdata));
    assert property (@(posedge clk40) disable iff (!rstN)
                     (dmaReq && !tbCfg.dmaEnable && !dmaGrant) |=> !dmaGrant)
        else begin
            errorCount++;
            $display("dmaGrant rose while DMA was disabled in test %s", testName);
        end
    assert property (@(posedge clk40) $rose(rstN) |-> (!ta && !cpuCycle && !dmaGrant
                     && !chipBus.strobe && !chipBus.uds && !chipBus.lds && memEnables == 4'hF
                     && ramEnables == 4'hF && cfgRdata == {2'(RESET_WS), 1'b1}))
        else begin
            errorCount++;
            $display("the bridge was not in its reset state when reset was released");
        end

    task automatic pulseTs(input cpuReq_t r);
        @(posedge clk40);
        ts     <= 1'b1;
        req    <= r;
        curReq <= r;
        @(posedge clk40);
        ts <= 1'b0;
    endtask

    // samples on the falling edge and returns on the rising edge after ta
    task automatic waitForTa();
        int cycles;
        cycles = 0;
        @(negedge clk40);
        while (!ta && cycles < WAIT_LIMIT) begin
            @(negedge clk40);
            cycles++;
        end
        if (!ta) begin
            errorCount++;
            $display("no ta arrived for the transfer in test %s", testName);
        end
        @(posedge clk40);
    endtask

    task automatic waitForGrant();
        int cycles;
        cycles = 0;
        @(negedge clk40);
        while (!dmaGrant && cycles < WAIT_LIMIT) begin
            @(negedge clk40);
            cycles++;
        end
        if (!dmaGrant) begin
            errorCount++;
            $display("dmaGrant never rose in test %s", testName);
        end
        @(posedge clk40);
    endtask

    task automatic cpuTransfer(input cpuReq_t r);
        pulseTs(r);
        waitForTa();
        transferCount++;
    endtask

    task automatic writeConfig(input bridgeCfg_t c);
        @(posedge clk40);
        cfgWrite <= 1'b1;
        cfgWdata <= c;
        @(posedge clk40);
        cfgWrite <= 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk40);
        $display("watchdog ran out after %0d cycles and stopped the run", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        cpuReq_t     r;
        bridgeCfg_t  newCfg;
        logic [31:0] pick;
        rstN     = 1'b0;
        ts       = 1'b0;
        req      = '0;
        curReq   = '0;
        dmaReq   = 1'b0;
        dma      = 3'b111;
        cfgWrite = 1'b0;
        cfgWdata = '0;
        testName = "reset";
        repeat (4) @(posedge clk40);
        rstN <= 1'b1;

        testName = "prefill";
        for (int i = 0; i < PREFILL_XFERS; i++) begin
            r           = randomReq(1'b0);
            r.siz       = sizeLong;
            r.addr[4:0] = {3'(i), 2'b00}; // one longword per model slot
            cpuTransfer(r);
        end

        testName = "random";
        for (int i = 0; i < RANDOM_XFERS; i++) begin
            pick = nextRandom();
            cpuTransfer(randomReq(pick[3]));
        end

        // new wait states land mid transfer, this one keeps the old count
        testName = "cfg during cycle";
        r           = randomReq(1'b1);
        r.siz       = sizeLong;
        r.addr[1:0] = 2'b00;
        pulseTs(r);
        newCfg.waitStates = 2'd3;
        newCfg.dmaEnable  = 1'b1;
        writeConfig(newCfg);
        waitForTa();
        transferCount++;

        testName = "wait states 3";
        for (int i = 0; i < WS_XFERS; i++) begin
            pick = nextRandom();
            cpuTransfer(randomReq(pick[3]));
        end
        newCfg.waitStates = 2'd0;
        writeConfig(newCfg);
        testName = "wait states 0";
        for (int i = 0; i < WS_XFERS; i++) begin
            pick = nextRandom();
            cpuTransfer(randomReq(pick[3]));
        end

        // CAS strobes wander while granted, then a ts waits behind the DMA
        testName = "dma";
        dmaReq <= 1'b1;
        waitForGrant();
        repeat (6) begin
            pick = nextRandom();
            dma <= pick[2:0];
            @(posedge clk40);
        end
        r = randomReq(pick[5]);
        pulseTs(r);
        repeat (3) begin
            pick = nextRandom();
            dma <= pick[2:0];
            @(posedge clk40);
        end
        dmaReq <= 1'b0;
        dma    <= 3'b111;
        waitForTa();
        transferCount++;

        testName = "dma disabled";
        newCfg.waitStates = 2'd1;
        newCfg.dmaEnable  = 1'b0;
        writeConfig(newCfg);
        dmaReq <= 1'b1;
        repeat (5) @(posedge clk40);
        cpuTransfer(randomReq(1'b1)); // the CPU still gets through
        repeat (5) @(posedge clk40);
        dmaReq <= 1'b0;
        newCfg.dmaEnable = 1'b1;
        writeConfig(newCfg);

        repeat (4) @(posedge clk40);
        $display("transfers %0d, errors %0d", transferCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* chipBridge.f */
design/chipBridgePkg.sv
design/byteEnable.sv
design/cycleSequencer.sv
design/dataSteer.sv
design/bridgeConfig.sv
design/chipBridge.sv
verification/chipBusModel.sv
verification/chipBridgeTb.sv
